// ==== common/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Register map in byte addresses.
`define ALU_REG_A 8'h00
`define ALU_REG_B 8'h04
`define ALU_REG_CTRL 8'h08
`define ALU_REG_STATUS 8'h0C
`define ALU_REG_RES_LO 8'h10
`define ALU_REG_RES_HI 8'h14

// STATUS bit positions.
`define ALU_ST_BUSY 0
`define ALU_ST_DONE 1
`define ALU_ST_DIVZ 2
`define ALU_ST_BADOP 3

// Iterations of the sequential units.
`define ALU_MUL_STEPS 32
`define ALU_DIV_STEPS 32

`endif

// ==== common/alu_pkg.sv ====
package alu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;
	typedef logic [4:0] shamt_t;

	// Encodings of the datapath opcode set.
	typedef enum logic [4:0] {
		ADD = 5'b00011,
		SUB = 5'b00100,
		AND = 5'b00101,
		OR = 5'b00110,
		SHR = 5'b00111,
		SHRA = 5'b01000,
		SHL = 5'b01001,
		ROR = 5'b01010,
		ROL = 5'b01011,
		MUL = 5'b01111,
		DIV = 5'b10000,
		NEG = 5'b10001,
		NOT = 5'b10010
	} opcode_t;

	typedef struct packed {
		logic [7:0] paddr;
		logic pwrite;
		word_t pwdata;
		logic psel;
		logic penable;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		IDLE,
		ALU_OP,
		MUL_OP,
		DIV_OP
	} seq_state_t;

endpackage

// ==== alu/shift_rotate.sv ====
`timescale 1ns/100ps

module shift_rotate (
	input alu_pkg::word_t value,
	input alu_pkg::shamt_t amount,
	input alu_pkg::opcode_t opcode,
	output alu_pkg::word_t shifted
);
	import alu_pkg::*;

	word_t stage [6];
	logic left;
	logic rotate;
	logic sign;

	function automatic word_t bit_rev(input word_t x);
		word_t r;
		for (int i = 0; i < 32; i++) begin
			r[i] = x[31 - i];
		end
		return r;
	endfunction

	// Left moves reuse the right shifter on a mirrored word.
	assign left = (opcode == SHL) || (opcode == ROL);
	assign rotate = (opcode == ROR) || (opcode == ROL);
	assign sign = (opcode == SHRA) & value[31];

	assign stage[0] = left ? bit_rev(value) : value;

	for (genvar i = 0; i < 5; i++) begin : g_stage
		localparam int S = 1 << i;
		word_t fill;

		// Wraparound bits or a replicated fill bit.
		assign fill = rotate ? stage[i] : {32{sign}};
		assign stage[i + 1] = amount[i] ? {fill[S - 1:0], stage[i][31:S]} : stage[i];
	end

	assign shifted = left ? bit_rev(stage[5]) : stage[5];

endmodule

// ==== alu/alu.sv ====
`timescale 1ns/100ps

module alu (
	input alu_pkg::word_t a,
	input alu_pkg::word_t b,
	input alu_pkg::opcode_t opcode,
	output alu_pkg::word_t result,
	output logic legal
);
	import alu_pkg::*;

	shamt_t amount;
	word_t shift_out;

	assign amount = b[4:0]; // Only the low five bits count.

	shift_rotate u_shift_rotate (
		.value(a),
		.amount(amount),
		.opcode(opcode),
		.shifted(shift_out)
	);

	always_comb begin
		legal = 1'b1;
		case (opcode)
			ADD: begin
				result = a + b; // Wraps at 32 bits.
			end
			SUB: begin
				result = a - b;
			end
			AND: begin
				result = a & b;
			end
			OR: begin
				result = a | b;
			end
			NEG: begin
				result = '0 - a;
			end
			NOT: begin
				result = ~a;
			end
			SHR, SHRA, SHL, ROR, ROL: begin
				result = shift_out;
			end
			MUL, DIV: begin
				// Handled by the sequential units.
				result = '0;
			end
			default: begin
				result = '0;
				legal = 1'b0;
			end
		endcase
	end

endmodule

// ==== source/booth_multiplier.sv ====
`timescale 1ns/100ps
`include "alu_macros.svh"

module booth_multiplier (
	input logic clk,
	input logic rst_n,
	input logic start,
	input alu_pkg::word_t multiplicand,
	input alu_pkg::word_t multiplier,
	output alu_pkg::dword_t product,
	output logic finish
);
	import alu_pkg::*;

	// Layout is accumulator [65:33], multiplier [32:1], Booth bit [0].
	logic [65:0] p;
	logic [65:0] p_next;
	logic [32:0] acc_next;
	word_t mcand;
	logic [5:0] count;
	logic active;

	always_comb begin
		// 33-bit accumulator keeps the most negative multiplicand in range.
		case (p[1:0])
			2'b01: begin
				acc_next = p[65:33] + {mcand[31], mcand};
			end
			2'b10: begin
				acc_next = p[65:33] - {mcand[31], mcand};
			end
			default: begin
				acc_next = p[65:33];
			end
		endcase
		p_next = {acc_next[32], acc_next, p[32:1]}; // Arithmetic shift right.
	end

	assign finish = active && (count == 6'(`ALU_MUL_STEPS - 1));

	// The product shows the result of the step in progress.
	assign product = p_next[64:1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			count <= '0;
		end else if (start) begin
			active <= 1'b1;
			count <= '0;
		end else if (active) begin
			count <= count + 6'd1;
			if (finish) begin
				active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			p <= {33'd0, multiplier, 1'b0};
			mcand <= multiplicand;
		end else if (active) begin
			p <= p_next;
		end
	end

endmodule

// ==== source/restoring_divider.sv ====
`timescale 1ns/100ps
`include "alu_macros.svh"

module restoring_divider (
	input logic clk,
	input logic rst_n,
	input logic start,
	input alu_pkg::word_t dividend,
	input alu_pkg::word_t divisor,
	output alu_pkg::word_t quotient,
	output alu_pkg::word_t remainder,
	output logic div_zero,
	output logic finish
);
	import alu_pkg::*;

	word_t quo;
	word_t rem;
	word_t dsr;
	word_t quo_next;
	word_t rem_next;
	logic [32:0] shifted;
	logic [33:0] trial;
	logic [5:0] count;
	logic active;

	// One shift, subtract and restore step.
	always_comb begin
		shifted = {rem, quo[31]};
		trial = {1'b0, shifted} - {2'b00, dsr};
		if (trial[33]) begin
			rem_next = shifted[31:0]; // Restore.
			quo_next = {quo[30:0], 1'b0};
		end else begin
			rem_next = trial[31:0];
			quo_next = {quo[30:0], 1'b1};
		end
	end

	// With a zero divisor every trial succeeds.
	// That leaves all ones in the quotient and the dividend as remainder.
	assign quotient = quo_next;
	assign remainder = rem_next;

	assign finish = active && (count == 6'(`ALU_DIV_STEPS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			count <= '0;
			div_zero <= 1'b0;
		end else if (start) begin
			active <= 1'b1;
			count <= '0;
			div_zero <= (divisor == '0);
		end else if (active) begin
			count <= count + 6'd1;
			if (finish) begin
				active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			quo <= dividend;
			rem <= '0;
			dsr <= divisor;
		end else if (active) begin
			quo <= quo_next;
			rem <= rem_next;
		end
	end

endmodule

// ==== source/alu_apb_regs.sv ====
`timescale 1ns/100ps
`include "alu_macros.svh"

module alu_apb_regs (
	input logic clk,
	input logic rst_n,
	input alu_pkg::apb_req_t apb_req,
	output alu_pkg::apb_rsp_t apb_rsp,
	output alu_pkg::word_t op_a,
	output alu_pkg::word_t op_b,
	output alu_pkg::opcode_t opcode,
	input alu_pkg::word_t alu_result,
	input logic alu_legal,
	output logic mul_start,
	input alu_pkg::dword_t mul_product,
	input logic mul_finish,
	output logic div_start,
	input alu_pkg::word_t div_quotient,
	input alu_pkg::word_t div_remainder,
	input logic div_zero,
	input logic div_finish
);
	import alu_pkg::*;

	seq_state_t state;
	dword_t result;
	word_t rdata;
	word_t status;
	opcode_t new_op;
	logic busy, done, divz, badop;
	logic mapped, res_read, ready, slv_err;
	logic access, wr_en, ctrl_wr, clr_done;

	assign busy = (state != IDLE);
	assign access = apb_req.psel & apb_req.penable;
	assign new_op = opcode_t'(apb_req.pwdata[4:0]);

	always_comb begin
		status = '0;
		status[`ALU_ST_BUSY] = busy;
		status[`ALU_ST_DONE] = done;
		status[`ALU_ST_DIVZ] = divz;
		status[`ALU_ST_BADOP] = badop;
	end

	always_comb begin
		mapped = 1'b1;
		res_read = 1'b0;
		case (apb_req.paddr)
			`ALU_REG_A: rdata = op_a;
			`ALU_REG_B: rdata = op_b;
			`ALU_REG_CTRL: rdata = {27'd0, opcode};
			`ALU_REG_STATUS: rdata = status;
			`ALU_REG_RES_LO: begin
				rdata = result[31:0];
				res_read = ~apb_req.pwrite;
			end
			`ALU_REG_RES_HI: begin
				rdata = result[63:32];
				res_read = ~apb_req.pwrite;
			end
			default: begin
				rdata = '0;
				mapped = 1'b0;
			end
		endcase
	end

	// Result reads stall until the running operation ends.
	assign ready = ~(apb_req.psel & res_read & busy);
	assign slv_err = access & ready & (~mapped |
		(apb_req.pwrite & (apb_req.paddr == `ALU_REG_CTRL) & busy));
	assign wr_en = access & apb_req.pwrite & ~slv_err;
	assign ctrl_wr = wr_en & (apb_req.paddr == `ALU_REG_CTRL);
	assign clr_done = wr_en & ((apb_req.paddr == `ALU_REG_A) |
		(apb_req.paddr == `ALU_REG_B) | (apb_req.paddr == `ALU_REG_CTRL));

	assign apb_rsp = '{prdata: rdata, pready: ready, pslverr: slv_err};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			done <= 1'b0;
			divz <= 1'b0;
			badop <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			op_a <= '0;
			op_b <= '0;
			opcode <= opcode_t'(5'd0);
			result <= '0;
		end else begin
			mul_start <= 1'b0;
			div_start <= 1'b0;
			if (wr_en && apb_req.paddr == `ALU_REG_A) op_a <= apb_req.pwdata;
			if (wr_en && apb_req.paddr == `ALU_REG_B) op_b <= apb_req.pwdata;
			if (clr_done) done <= 1'b0;
			if (ctrl_wr) opcode <= new_op;
			case (state)
				IDLE: begin
					if (ctrl_wr) begin
						case (new_op)
							MUL: begin
								state <= MUL_OP;
								mul_start <= 1'b1;
							end
							DIV: begin
								state <= DIV_OP;
								div_start <= 1'b1;
							end
							default: state <= ALU_OP; // Illegal codes too.
						endcase
					end
				end
				ALU_OP: begin
					result <= alu_legal ? {32'd0, alu_result} : '0;
					badop <= ~alu_legal;
					divz <= 1'b0;
					done <= 1'b1;
					state <= IDLE;
				end
				MUL_OP: begin
					if (mul_finish) begin
						result <= mul_product;
						badop <= 1'b0;
						divz <= 1'b0;
						done <= 1'b1;
						state <= IDLE;
					end
				end
				DIV_OP: begin
					if (div_finish) begin
						result <= {div_remainder, div_quotient};
						badop <= 1'b0;
						divz <= div_zero;
						done <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== source/alu_top.sv ====
`timescale 1ns/100ps

module alu_top (
	input logic clk,
	input logic rst_n,
	input alu_pkg::apb_req_t apb_req,
	output alu_pkg::apb_rsp_t apb_rsp
);
	import alu_pkg::*;

	word_t op_a, op_b, alu_result, div_quotient, div_remainder;
	opcode_t opcode;
	dword_t mul_product;
	logic alu_legal, mul_start, mul_finish, div_start, div_zero, div_finish;

	alu_apb_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.op_a(op_a), .op_b(op_b), .opcode(opcode),
		.alu_result(alu_result), .alu_legal(alu_legal),
		.mul_start(mul_start), .mul_product(mul_product), .mul_finish(mul_finish),
		.div_start(div_start), .div_quotient(div_quotient),
		.div_remainder(div_remainder), .div_zero(div_zero), .div_finish(div_finish)
	);

	alu u_alu (
		.a(op_a), .b(op_b), .opcode(opcode),
		.result(alu_result), .legal(alu_legal)
	);

	booth_multiplier u_mul (
		.clk(clk), .rst_n(rst_n), .start(mul_start),
		.multiplicand(op_a), .multiplier(op_b),
		.product(mul_product), .finish(mul_finish)
	);

	restoring_divider u_div (
		.clk(clk), .rst_n(rst_n), .start(div_start),
		.dividend(op_a), .divisor(op_b),
		.quotient(div_quotient), .remainder(div_remainder),
		.div_zero(div_zero), .finish(div_finish)
	);

endmodule

// ==== bench/alu_checker.sv ====
`timescale 1ns/100ps

module alu_checker (
	input logic clk,
	input logic rst_n,
	input alu_pkg::apb_req_t apb_req,
	input alu_pkg::apb_rsp_t apb_rsp,
	input logic busy,
	input logic done,
	input logic mul_start,
	input logic div_start
);

	int error_count;

	initial error_count = 0;

	// Access phase only after a setup phase.
	a_setup_first: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
		else begin $error("penable rose without a setup cycle"); error_count++; end
	a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.penable |-> apb_req.psel)
		else begin $error("penable high without psel"); error_count++; end

	a_stable_wait: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.psel && apb_req.penable && !apb_rsp.pready |=> $stable(apb_req))
		else begin $error("APB request changed during a wait state"); error_count++; end

	a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> done)
		else begin $error("busy fell without done"); error_count++; end

	// Start strobes last one cycle.
	a_mul_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		mul_start |=> !mul_start)
		else begin $error("mul_start longer than one cycle"); error_count++; end
	a_div_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		div_start |=> !div_start)
		else begin $error("div_start longer than one cycle"); error_count++; end

endmodule

bind alu_apb_regs alu_checker u_checker (
	.clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
	.busy(busy), .done(done), .mul_start(mul_start), .div_start(div_start)
);

// ==== bench/alu_tb.sv ====
`timescale 1ns/100ps
`include "alu_macros.svh"

module alu_tb;
	import alu_pkg::*;

	logic clk;
	logic rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic [31:0] lfsr;
	logic [4:0] alu_ops [11];
	int fails, tests_passed, tests_failed;

	alu_top u_dut (.clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1.
	function automatic word_t rand_bits(input int n);
		word_t v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_value(input string what, input dword_t got, input dword_t exp);
		assert (got === exp) else begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			fails++;
		end
	endtask

	// One transfer. waits counts access cycles with pready low.
	task automatic apb_xfer(input logic [7:0] addr, input logic wr, input word_t wdata,
			output word_t rdata, output logic err, output int waits);
		logic ready;
		@(negedge clk);
		apb_req = '{paddr: addr, pwrite: wr, pwdata: wdata, psel: 1'b1, penable: 1'b0};
		@(negedge clk);
		apb_req.penable = 1'b1;
		waits = 0;
		ready = 1'b0;
		while (!ready && waits < 100) begin
			#1;
			ready = apb_rsp.pready;
			rdata = apb_rsp.prdata;
			err = apb_rsp.pslverr;
			if (!ready) begin
				waits++;
				@(negedge clk);
			end
		end
		if (!ready) begin
			$display("Timeout: pready stayed low for %0d cycles at address %h", waits, addr);
			$display("Test FAILED");
			$finish;
		end else begin
			@(posedge clk); // Completing edge.
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input word_t data, output logic err);
		word_t rdata;
		int waits;
		apb_xfer(addr, 1'b1, data, rdata, err, waits);
	endtask

	task automatic apb_read(input logic [7:0] addr, output word_t data, output logic err,
			output int waits);
		apb_xfer(addr, 1'b0, '0, data, err, waits);
	endtask

	// Expected result and flags from the opcode definitions.
	task automatic model_op(input logic [4:0] op, input word_t a, input word_t b,
			output dword_t res, output logic divz, output logic badop);
		logic signed [63:0] sa, sb;
		dword_t twice;
		int sh;
		sa = $signed(a);
		sb = $signed(b);
		twice = {a, a};
		sh = b[4:0];
		res = '0;
		divz = 1'b0;
		badop = 1'b0;
		case (op)
			ADD: res[31:0] = a + b;
			SUB: res[31:0] = a - b;
			AND: res[31:0] = a & b;
			OR: res[31:0] = a | b;
			NEG: res[31:0] = -a;
			NOT: res[31:0] = ~a;
			SHR: res[31:0] = a >> sh;
			SHRA: res[31:0] = $signed(a) >>> sh;
			SHL: res[31:0] = a << sh;
			ROR: res[31:0] = twice >> sh;
			ROL: res[31:0] = twice >> (32 - sh); // Left by n is right by 32 - n.
			MUL: res = sa * sb;
			DIV: begin
				if (b == '0) begin
					res = {a, 32'hffff_ffff};
					divz = 1'b1;
				end else begin
					res = {a % b, a / b};
				end
			end
			default: badop = 1'b1;
		endcase
	endtask

	task automatic run_op(input logic [4:0] op, input word_t a, input word_t b);
		dword_t exp_res;
		logic exp_divz, exp_badop, err;
		word_t lo, hi, st, exp_st;
		int waits, exp_waits, hi_waits;
		string id;
		id = $sformatf("op %h a %h b %h", op, a, b);
		model_op(op, a, b, exp_res, exp_divz, exp_badop);
		// Busy spans steps + 1 cycles and the setup phase takes one.
		exp_waits = (op == MUL) ? `ALU_MUL_STEPS : (op == DIV) ? `ALU_DIV_STEPS : 0;
		exp_st = '0;
		exp_st[`ALU_ST_DONE] = 1'b1;
		exp_st[`ALU_ST_DIVZ] = exp_divz;
		exp_st[`ALU_ST_BADOP] = exp_badop;
		apb_write(`ALU_REG_A, a, err);
		apb_write(`ALU_REG_B, b, err);
		apb_write(`ALU_REG_CTRL, {27'd0, op}, err);
		check_value({id, " CTRL pslverr"}, err, 0);
		apb_read(`ALU_REG_RES_LO, lo, err, waits); // Issued while busy.
		check_value({id, " wait states"}, waits, exp_waits);
		apb_read(`ALU_REG_RES_HI, hi, err, hi_waits);
		check_value({id, " RES_HI wait states"}, hi_waits, 0);
		check_value({id, " result"}, {hi, lo}, exp_res);
		apb_read(`ALU_REG_STATUS, st, err, waits);
		check_value({id, " STATUS"}, st, exp_st);
	endtask

	task automatic end_test(input string name, input int mark);
		if (fails == mark) begin
			tests_passed++;
			$display("[pass] %s", name);
		end else begin
			tests_failed++;
			$display("[fail] %s, %0d failed checks", name, fails - mark);
		end
	endtask

	initial begin
		word_t a, b, lo, hi, rd;
		logic err, exp_divz, exp_badop;
		int waits, mark;
		dword_t exp_res;
		rst_n = 1'b0;
		apb_req = '0;
		lfsr = 32'ha640;
		alu_ops = '{ADD, SUB, AND, OR, SHR, SHRA, SHL, ROR, ROL, NEG, NOT};
		fails = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		mark = fails;
		apb_read(`ALU_REG_STATUS, rd, err, waits);
		check_value("reset STATUS", rd, 0);
		check_value("reset pslverr", err, 0);
		apb_read(`ALU_REG_RES_LO, rd, err, waits);
		check_value("reset RES_LO", rd, 0);
		check_value("reset wait states", waits, 0);
		apb_read(`ALU_REG_RES_HI, rd, err, waits);
		check_value("reset RES_HI", rd, 0);
		end_test("reset values", mark);

		mark = fails;
		for (int i = 0; i < 200; i++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			run_op(alu_ops[rand_bits(4) % 11], a, b);
		end
		end_test("200 single-cycle operations", mark);

		mark = fails;
		for (int i = 0; i < 50; i++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			run_op(MUL, a, b);
		end
		end_test("50 multiplies", mark);

		mark = fails;
		for (int i = 0; i < 50; i++) begin
			a = rand_bits(32);
			b = rand_bits(32) >> rand_bits(5); // Spread divisor sizes.
			if (i % 8 == 0) b = '0;
			run_op(DIV, a, b);
		end
		end_test("50 divides", mark);

		mark = fails;
		a = rand_bits(32);
		b = rand_bits(32);
		run_op(5'h0d, a, b);
		model_op(MUL, a, b, exp_res, exp_divz, exp_badop);
		apb_write(`ALU_REG_CTRL, word_t'(MUL), err);
		apb_write(`ALU_REG_CTRL, word_t'(ADD), err);
		check_value("pslverr on CTRL write while busy", err, 1);
		apb_read(`ALU_REG_RES_LO, lo, err, waits);
		apb_read(`ALU_REG_RES_HI, hi, err, waits);
		check_value("product after refused CTRL write", {hi, lo}, exp_res);
		apb_write(8'h20, a, err);
		check_value("pslverr on unmapped write", err, 1);
		apb_read(8'h18, rd, err, waits);
		check_value("pslverr on unmapped read", err, 1);
		end_test("error cases", mark);

		mark = fails;
		check_value("protocol assertion failures", u_dut.u_regs.u_checker.error_count, 0);
		end_test("protocol checker", mark);

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+common
common/alu_pkg.sv
alu/shift_rotate.sv
alu/alu.sv
source/booth_multiplier.sv
source/restoring_divider.sv
source/alu_apb_regs.sv
source/alu_top.sv
bench/alu_checker.sv
bench/alu_tb.sv
